/* common/axil_pkg.sv */
package axil_pkg;

   localparam int ADDR_W = 4;
   localparam int DATA_W = 32;

   // ------------------------------------------------------------------
   // Channel payloads. Valid and ready travel as separate bits.
   // ------------------------------------------------------------------
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
   } axil_aw_t;

   typedef struct packed {
      logic [DATA_W-1:0]   data;
      logic [DATA_W/8-1:0] strb;  // Ignored, full-word writes only.
   } axil_w_t;

   typedef struct packed {
      logic [1:0] resp;
   } axil_b_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
   } axil_ar_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [1:0]        resp;
   } axil_r_t;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   // ------------------------------------------------------------------
   // Register map.
   // ------------------------------------------------------------------
   localparam logic [ADDR_W-1:0] REG_OPERAND = 4'h0;  // Write only.
   localparam logic [ADDR_W-1:0] REG_RESULT  = 4'h4;  // Read only, pops.
   localparam logic [ADDR_W-1:0] REG_STATUS  = 4'h8;  // Read only.

   // Field positions inside the data word.
   localparam int OPERAND_DIVISOR_LSB  = 16;
   localparam int RESULT_QUOTIENT_LSB  = 16;
   localparam int RESULT_OVERFLOW_BIT  = 31;
   localparam int STATUS_OP_COUNT_LSB  = 0;
   localparam int STATUS_RES_COUNT_LSB = 8;
   localparam int STATUS_CNT_W         = 8;

endpackage

/* common/div_pkg.sv */
package div_pkg;

   // ------------------------------------------------------------------
   // Operand and result widths.
   // ------------------------------------------------------------------
   localparam int DIVIDEND_W = 11;  // Also the remainder width.
   localparam int DIVISOR_W  = 4;
   localparam int QUOTIENT_W = 8;   // One pipeline step per quotient bit.

   // ------------------------------------------------------------------
   // Queue payloads.
   // ------------------------------------------------------------------

   // Operand pair as taken from the operand register.
   typedef struct packed {
      logic [DIVIDEND_W-1:0] dividend;
      logic [DIVISOR_W-1:0]  divisor;
   } div_operand_t;

   // Finished division. On overflow the quotient saturates
   // and the remainder carries the dividend.
   typedef struct packed {
      logic                  overflow;
      logic [QUOTIENT_W-1:0] quotient;
      logic [DIVIDEND_W-1:0] remainder;
   } div_result_t;

endpackage

/* div_pipeline/div_pipeline.sv */
`timescale 1ns/1ps

module div_pipeline #(
   parameter int RESULT_DEPTH = 4
) (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                op_empty,
   output logic                                op_pop,
   input  div_pkg::div_operand_t               op_data,
   input  logic [$clog2(RESULT_DEPTH+1)-1:0]   res_count,
   output logic                                res_push,
   output div_pkg::div_result_t                res_data
);

   localparam int CNT_W   = $clog2(RESULT_DEPTH + 1);
   localparam int QW      = div_pkg::QUOTIENT_W;
   localparam int DVD_W   = div_pkg::DIVIDEND_W;
   localparam int DIFF_W  = DVD_W + 1;
   localparam int LIMIT_W = div_pkg::DIVISOR_W + QW;
   localparam int STAGES  = QW + 1;  // Overflow check plus one per bit.

   typedef struct packed {
      logic                          overflow;
      logic [div_pkg::DIVISOR_W-1:0] divisor;
      logic [QW-1:0]                 quotient;
      logic [DVD_W-1:0]              rem;
   } stage_t;

   stage_t              stage_q [STAGES];
   logic [STAGES-1:0]   stage_vld;
   logic [CNT_W-1:0]    in_flight;
   logic [CNT_W:0]      credits_used;
   logic [LIMIT_W-1:0]  limit;
   logic                entry_ovf;

   // ------------------------------------------------------------------
   // Issue control. Every item in flight owns a slot in the result
   // queue, so the pipeline never has to stall.
   // ------------------------------------------------------------------
   assign credits_used = {1'b0, in_flight} + {1'b0, res_count};
   assign op_pop       = !op_empty && (credits_used < (CNT_W+1)'(RESULT_DEPTH));

   always_ff @(posedge clk)
   begin
      if (reset)
         in_flight <= '0;
      else if (op_pop && !res_push)
         in_flight <= in_flight + 1'b1;
      else if (res_push && !op_pop)
         in_flight <= in_flight - 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         stage_vld <= '0;
      else
         stage_vld <= {stage_vld[STAGES-2:0], op_pop};
   end

   // ------------------------------------------------------------------
   // Entry stage. Quotient would need more than QW bits.
   // ------------------------------------------------------------------
   assign limit     = {op_data.divisor, {QW{1'b0}}};
   assign entry_ovf = (op_data.divisor == '0) || (LIMIT_W'(op_data.dividend) >= limit);

   always_ff @(posedge clk)
   begin
      stage_q[0].overflow <= entry_ovf;
      stage_q[0].divisor  <= op_data.divisor;
      stage_q[0].quotient <= '0;
      stage_q[0].rem      <= op_data.dividend;
   end

   // ------------------------------------------------------------------
   // Restoring steps, most significant quotient bit first.
   // ------------------------------------------------------------------
   for (genvar i = 0; i < QW; i++)
   begin : g_step
      localparam int SHIFT = QW - 1 - i;

      logic [DVD_W-1:0]  sub_val;
      logic [DIFF_W-1:0] diff;

      assign sub_val = DVD_W'(stage_q[i].divisor) << SHIFT;
      assign diff    = {1'b0, stage_q[i].rem} - {1'b0, sub_val};  // Extra bit is the sign.

      always_ff @(posedge clk)
      begin
         stage_q[i+1].overflow <= stage_q[i].overflow;
         stage_q[i+1].divisor  <= stage_q[i].divisor;
         if (stage_q[i].overflow)
         begin
            stage_q[i+1].rem      <= stage_q[i].rem;  // Saturate.
            stage_q[i+1].quotient <= {stage_q[i].quotient[QW-2:0], 1'b1};
         end
         else if (!diff[DIFF_W-1])
         begin
            stage_q[i+1].rem      <= diff[DVD_W-1:0];
            stage_q[i+1].quotient <= {stage_q[i].quotient[QW-2:0], 1'b1};
         end
         else
         begin
            stage_q[i+1].rem      <= stage_q[i].rem;
            stage_q[i+1].quotient <= {stage_q[i].quotient[QW-2:0], 1'b0};
         end
      end
   end

   assign res_push = stage_vld[STAGES-1];

   always_comb
   begin
      res_data.overflow  = stage_q[STAGES-1].overflow;
      res_data.quotient  = stage_q[STAGES-1].quotient;
      res_data.remainder = stage_q[STAGES-1].rem;
   end

endmodule

/* files.f */
+incdir+verif
common/div_pkg.sv
common/axil_pkg.sv
src/sync_fifo.sv
src/axil_write_port.sv
src/axil_read_port.sv
div_pipeline/div_pipeline.sv
src/div_unit_top.sv
verif/div_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the division unit testbench with Verilator, runs it and
# checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=div_unit_sim
LOG=sim.log

verilator --binary --timing -Wno-fatal \
   -f files.f \
   --top-module div_unit_tb \
   -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
   echo "Simulation reported failure"
   exit 1
fi

exit 0

/* src/axil_read_port.sv */
`timescale 1ns/1ps

module axil_read_port (
   input  logic                                  clk,
   input  logic                                  reset,
   // Read address.
   input  logic                                  arvalid,
   output logic                                  arready,
   input  axil_pkg::axil_ar_t                    ar,
   // Read data.
   output logic                                  rvalid,
   input  logic                                  rready,
   output axil_pkg::axil_r_t                     r,
   // Result queue.
   input  logic                                  res_empty,
   output logic                                  res_pop,
   input  div_pkg::div_result_t                  res_data,
   // Queue occupancy for the status word.
   input  logic [axil_pkg::STATUS_CNT_W-1:0]     op_count,
   input  logic [axil_pkg::STATUS_CNT_W-1:0]     res_count
);

   logic                        rd_fire;
   logic                        is_result;
   logic                        is_status;
   logic [axil_pkg::DATA_W-1:0] rd_data;
   logic [1:0]                  rd_resp;

   assign arready   = !rvalid;
   assign rd_fire   = arvalid && !rvalid;
   assign is_result = (ar.addr == axil_pkg::REG_RESULT);
   assign is_status = (ar.addr == axil_pkg::REG_STATUS);
   assign res_pop   = rd_fire && is_result && !res_empty;

   // ------------------------------------------------------------------
   // Read data formatting.
   // ------------------------------------------------------------------
   always_comb
   begin
      rd_data = '0;
      rd_resp = axil_pkg::RESP_SLVERR;
      if (is_result && !res_empty)
      begin
         rd_data[axil_pkg::RESULT_OVERFLOW_BIT] = res_data.overflow;
         rd_data[axil_pkg::RESULT_QUOTIENT_LSB +: div_pkg::QUOTIENT_W] = res_data.quotient;
         rd_data[div_pkg::DIVIDEND_W-1:0] = res_data.remainder;
         rd_resp = axil_pkg::RESP_OKAY;
      end
      else if (is_status)
      begin
         rd_data[axil_pkg::STATUS_OP_COUNT_LSB +: axil_pkg::STATUS_CNT_W]  = op_count;
         rd_data[axil_pkg::STATUS_RES_COUNT_LSB +: axil_pkg::STATUS_CNT_W] = res_count;
         rd_resp = axil_pkg::RESP_OKAY;
      end
   end

   // ------------------------------------------------------------------
   // Read response, held until taken.
   // ------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
         rvalid <= 1'b0;
      else if (rd_fire)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (rd_fire)
      begin
         r.data <= rd_data;
         r.resp <= rd_resp;
      end
   end

endmodule

/* src/axil_write_port.sv */
`timescale 1ns/1ps

module axil_write_port (
   input  logic                  clk,
   input  logic                  reset,
   // Write address.
   input  logic                  awvalid,
   output logic                  awready,
   input  axil_pkg::axil_aw_t    aw,
   // Write data.
   input  logic                  wvalid,
   output logic                  wready,
   input  axil_pkg::axil_w_t     w,
   // Write response.
   output logic                  bvalid,
   input  logic                  bready,
   output axil_pkg::axil_b_t     b,
   // Operand queue.
   input  logic                  op_full,
   output logic                  op_push,
   output div_pkg::div_operand_t op_data
);

   logic wr_fire;
   logic addr_ok;

   // Address and data are taken together, never while a response waits.
   assign wr_fire = awvalid && wvalid && !bvalid;
   assign awready = wr_fire;
   assign wready  = wr_fire;

   assign addr_ok = (aw.addr == axil_pkg::REG_OPERAND);
   assign op_push = wr_fire && addr_ok && !op_full;  // Full queue drops it.

   // ------------------------------------------------------------------
   // Operand fields.
   // ------------------------------------------------------------------
   always_comb
   begin
      op_data.dividend = w.data[div_pkg::DIVIDEND_W-1:0];
      op_data.divisor  = w.data[axil_pkg::OPERAND_DIVISOR_LSB +: div_pkg::DIVISOR_W];
   end

   // ------------------------------------------------------------------
   // Write response.
   // ------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
         bvalid <= 1'b0;
      else if (wr_fire)
         bvalid <= 1'b1;
      else if (bready)
         bvalid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (wr_fire)
      begin
         if (addr_ok && !op_full)
            b.resp <= axil_pkg::RESP_OKAY;
         else
            b.resp <= axil_pkg::RESP_SLVERR;  // Bad address or no room.
      end
   end

endmodule

/* src/div_unit_top.sv */
`timescale 1ns/1ps

module div_unit_top #(
   parameter int OPERAND_DEPTH = 4,
   parameter int RESULT_DEPTH  = 4
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               awvalid,
   output logic               awready,
   input  axil_pkg::axil_aw_t aw,
   input  logic               wvalid,
   output logic               wready,
   input  axil_pkg::axil_w_t  w,
   output logic               bvalid,
   input  logic               bready,
   output axil_pkg::axil_b_t  b,
   input  logic               arvalid,
   output logic               arready,
   input  axil_pkg::axil_ar_t ar,
   output logic               rvalid,
   input  logic               rready,
   output axil_pkg::axil_r_t  r
);

   localparam int OP_CNT_W  = $clog2(OPERAND_DEPTH + 1);
   localparam int RES_CNT_W = $clog2(RESULT_DEPTH + 1);
   localparam int STAT_W    = axil_pkg::STATUS_CNT_W;

   logic                  op_full;
   logic                  op_empty;
   logic                  op_push;
   logic                  op_pop;
   div_pkg::div_operand_t op_wr_data;
   div_pkg::div_operand_t op_rd_data;
   logic [OP_CNT_W-1:0]   op_count;
   logic                  res_empty;
   logic                  res_push;
   logic                  res_pop;
   div_pkg::div_result_t  res_wr_data;
   div_pkg::div_result_t  res_rd_data;
   logic [RES_CNT_W-1:0]  res_count;
   logic [STAT_W-1:0]     op_count_st;
   logic [STAT_W-1:0]     res_count_st;

   // Counts widened to the status field.
   assign op_count_st  = {{(STAT_W - OP_CNT_W){1'b0}}, op_count};
   assign res_count_st = {{(STAT_W - RES_CNT_W){1'b0}}, res_count};

   axil_write_port wr_port0 (
      .clk(clk), .reset(reset),
      .awvalid(awvalid), .awready(awready), .aw(aw),
      .wvalid(wvalid), .wready(wready), .w(w),
      .bvalid(bvalid), .bready(bready), .b(b),
      .op_full(op_full), .op_push(op_push), .op_data(op_wr_data)
   );

   sync_fifo #(.payload_t(div_pkg::div_operand_t), .DEPTH(OPERAND_DEPTH)) op_fifo0 (
      .clk(clk), .reset(reset),
      .push(op_push), .push_data(op_wr_data),
      .pop(op_pop), .pop_data(op_rd_data),
      .full(op_full), .empty(op_empty), .count(op_count)
   );

   div_pipeline #(.RESULT_DEPTH(RESULT_DEPTH)) pipe0 (
      .clk(clk), .reset(reset),
      .op_empty(op_empty), .op_pop(op_pop), .op_data(op_rd_data),
      .res_count(res_count), .res_push(res_push), .res_data(res_wr_data)
   );

   // Full is never seen here, the pipeline credits keep room.
   sync_fifo #(.payload_t(div_pkg::div_result_t), .DEPTH(RESULT_DEPTH)) res_fifo0 (
      .clk(clk), .reset(reset),
      .push(res_push), .push_data(res_wr_data),
      .pop(res_pop), .pop_data(res_rd_data),
      .full(), .empty(res_empty), .count(res_count)
   );

   axil_read_port rd_port0 (
      .clk(clk), .reset(reset),
      .arvalid(arvalid), .arready(arready), .ar(ar),
      .rvalid(rvalid), .rready(rready), .r(r),
      .res_empty(res_empty), .res_pop(res_pop), .res_data(res_rd_data),
      .op_count(op_count_st), .res_count(res_count_st)
   );

endmodule

/* src/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  DEPTH     = 4
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       push,
   input  payload_t                   push_data,
   input  logic                       pop,
   output payload_t                   pop_data,
   output logic                       full,
   output logic                       empty,
   output logic [$clog2(DEPTH+1)-1:0] count
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop)
            rd_ptr <= next_ptr(rd_ptr);
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   assign pop_data = mem[rd_ptr];  // Head of queue, shown before the pop.
   assign full     = (count == CNT_W'(DEPTH));
   assign empty    = (count == '0);

endmodule

/* verif/axil_tasks.svh */
`ifndef AXIL_TASKS_SVH
`define AXIL_TASKS_SVH

// ----------------------------------------------------------------------
// AXI4-Lite bus tasks. Inputs change on the falling edge, and ready is
// sampled 1 ns later, after the combinational paths have settled.
// ----------------------------------------------------------------------

// One register write with AW and W presented together, then the B response.
task automatic write_reg(input logic [axil_pkg::ADDR_W-1:0] addr,
                         input logic [axil_pkg::DATA_W-1:0] data,
                         output logic [1:0] resp);
   int cnt;
   @(negedge clk);
   aw.addr = addr;
   awvalid = 1'b1;
   w.data  = data;
   w.strb  = '1;
   wvalid  = 1'b1;
   cnt     = 0;
   #1;
   while (!(awready && wready) && cnt < WAIT_LIMIT)
   begin
      @(negedge clk);
      #1;
      cnt++;
   end
   if (!(awready && wready))
      abort_run("write address and data were never accepted");
   @(negedge clk);  // Transfer took place on the rising edge before this.
   awvalid = 1'b0;
   wvalid  = 1'b0;
   bready  = 1'b1;
   cnt     = 0;
   while (!bvalid && cnt < WAIT_LIMIT)
   begin
      @(negedge clk);
      cnt++;
   end
   if (!bvalid)
      abort_run("write response never arrived");
   resp = b.resp;
   @(negedge clk);
   bready = 1'b0;
endtask

task automatic read_reg(input logic [axil_pkg::ADDR_W-1:0] addr,
                        output logic [axil_pkg::DATA_W-1:0] data,
                        output logic [1:0] resp);
   int cnt;
   @(negedge clk);
   ar.addr = addr;
   arvalid = 1'b1;
   cnt     = 0;
   #1;
   while (!arready && cnt < WAIT_LIMIT)
   begin
      @(negedge clk);
      #1;
      cnt++;
   end
   if (!arready)
      abort_run("read address was never accepted");
   @(negedge clk);
   arvalid = 1'b0;
   rready  = 1'b1;
   cnt     = 0;
   while (!rvalid && cnt < WAIT_LIMIT)
   begin
      @(negedge clk);
      cnt++;
   end
   if (!rvalid)
      abort_run("read response never arrived");
   data = r.data;
   resp = r.resp;
   @(negedge clk);
   rready = 1'b0;
endtask

// Polls the result register until a result is there.
task automatic read_result(output logic [axil_pkg::DATA_W-1:0] data);
   logic [1:0] resp;
   int         polls;
   polls = 0;
   resp  = axil_pkg::RESP_SLVERR;
   while (resp != axil_pkg::RESP_OKAY && polls < POLL_LIMIT)
   begin
      read_reg(axil_pkg::REG_RESULT, data, resp);
      polls++;
   end
   if (resp != axil_pkg::RESP_OKAY)
      abort_run("result queue stayed empty");
endtask

`endif

/* verif/div_unit_tb.sv */
`timescale 1ns/1ps

module div_unit_tb;

   localparam int OP_DEPTH   = 4;
   localparam int RES_DEPTH  = 4;
   localparam int N_FIXED    = 6;
   localparam int N_ENTRIES  = N_FIXED + 20;
   localparam int WAIT_LIMIT = 50;  // Cycles per handshake.
   localparam int POLL_LIMIT = 40;  // Register reads per poll.

   logic               clk;
   logic               reset;
   logic               awvalid;
   logic               awready;
   axil_pkg::axil_aw_t aw;
   logic               wvalid;
   logic               wready;
   axil_pkg::axil_w_t  w;
   logic               bvalid;
   logic               bready;
   axil_pkg::axil_b_t  b;
   logic               arvalid;
   logic               arready;
   axil_pkg::axil_ar_t ar;
   logic               rvalid;
   logic               rready;
   axil_pkg::axil_r_t  r;

   int          errors;
   int          checks;
   integer      seed;
   int          dvd_tab [N_ENTRIES];
   int          dvs_tab [N_ENTRIES];
   logic [31:0] exp_tab [N_ENTRIES];
   logic [31:0] rd_data;
   logic [1:0]  resp;

   div_unit_top #(.OPERAND_DEPTH(OP_DEPTH), .RESULT_DEPTH(RES_DEPTH)) dut0 (
      .clk(clk), .reset(reset),
      .awvalid(awvalid), .awready(awready), .aw(aw),
      .wvalid(wvalid), .wready(wready), .w(w),
      .bvalid(bvalid), .bready(bready), .b(b),
      .arvalid(arvalid), .arready(arready), .ar(ar),
      .rvalid(rvalid), .rready(rready), .r(r)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic abort_run(input string what);
      $display("TIMEOUT: %s", what);
      $display("errors: %0d, checks: %0d", errors + 1, checks);
      $display("STATUS: FAIL");
      $finish;
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected)
      begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   // Saturated form when the quotient cannot fit in 8 bits.
   function automatic logic [31:0] expected_word(input int dividend, input int divisor);
      logic [31:0] word;
      word = '0;
      if (divisor == 0 || dividend >= divisor * 256)
      begin
         word[31]    = 1'b1;
         word[23:16] = 8'hff;
         word[10:0]  = 11'(dividend);
      end
      else
      begin
         word[23:16] = 8'(dividend / divisor);
         word[10:0]  = 11'(dividend % divisor);
      end
      return word;
   endfunction

   function automatic logic [31:0] operand_word(input int idx);
      logic [31:0] word;
      word        = '0;
      word[10:0]  = 11'(dvd_tab[idx]);
      word[19:16] = 4'(dvs_tab[idx]);
      return word;
   endfunction

   task automatic build_table();
      dvd_tab[0] = 100;
      dvs_tab[0] = 0;     // Zero divisor.
      dvd_tab[1] = 120;
      dvs_tab[1] = 8;     // Exact.
      dvd_tab[2] = 127;
      dvs_tab[2] = 8;
      dvd_tab[3] = 1280;
      dvs_tab[3] = 5;     // Exactly 256 times the divisor.
      dvd_tab[4] = 2047;
      dvs_tab[4] = 8;
      dvd_tab[5] = 2047;
      dvs_tab[5] = 15;
      for (int i = N_FIXED; i < N_ENTRIES; i++)
      begin
         dvd_tab[i] = $random(seed) & 32'h7ff;
         dvs_tab[i] = $random(seed) & 32'hf;
      end
      for (int i = 0; i < N_ENTRIES; i++)
         exp_tab[i] = expected_word(dvd_tab[i], dvs_tab[i]);
   endtask

   `include "axil_tasks.svh"

   initial
   begin
      reset   = 1'b1;
      awvalid = 1'b0;
      aw      = '0;
      wvalid  = 1'b0;
      w       = '0;
      bready  = 1'b0;
      arvalid = 1'b0;
      ar      = '0;
      rready  = 1'b0;
      errors  = 0;
      checks  = 0;
      seed    = 32'hca07;
      build_table();
      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // -------------------------------------------------------------------
      // Arithmetic with one division at a time. Overflow rows also get a
      // whole-word check on the saturated form.
      // -------------------------------------------------------------------
      for (int i = 0; i < N_ENTRIES; i++)
      begin
         write_reg(axil_pkg::REG_OPERAND, operand_word(i), resp);
         check_value("b.resp", axil_pkg::RESP_OKAY, resp);
         read_result(rd_data);
         check_value("r.data quotient", exp_tab[i][23:16], rd_data[23:16]);
         check_value("r.data remainder", exp_tab[i][10:0], rd_data[10:0]);
         check_value("r.data overflow", exp_tab[i][31], rd_data[31]);
         if (exp_tab[i][31])
            check_value("r.data saturated", exp_tab[i], rd_data);
      end

      // -------------------------------------------------------------------
      // Back-pressure. Both queues fill before one write too many.
      // A bad-address write goes in while all result credits are taken.
      // A stray push would then stay in the operand queue.
      // -------------------------------------------------------------------
      for (int i = 0; i < OP_DEPTH + RES_DEPTH; i++)
      begin
         write_reg(axil_pkg::REG_OPERAND, operand_word(N_FIXED + i), resp);
         check_value("b.resp", axil_pkg::RESP_OKAY, resp);
         if (i == RES_DEPTH - 1)
         begin
            write_reg(axil_pkg::REG_RESULT, operand_word(1), resp);
            check_value("b.resp bad address", axil_pkg::RESP_SLVERR, resp);
            read_reg(axil_pkg::REG_STATUS, rd_data, resp);
            check_value("r.resp status", axil_pkg::RESP_OKAY, resp);
            check_value("r.data op count", 8'h0, rd_data[7:0]);
         end
      end
      write_reg(axil_pkg::REG_OPERAND, operand_word(N_FIXED + OP_DEPTH + RES_DEPTH), resp);
      check_value("b.resp", axil_pkg::RESP_SLVERR, resp);
      for (int p = 0; p < POLL_LIMIT; p++)
      begin
         read_reg(axil_pkg::REG_STATUS, rd_data, resp);
         if (rd_data[15:0] == {8'(RES_DEPTH), 8'(OP_DEPTH)})
            break;
      end
      check_value("r.data status", {16'h0, 8'(RES_DEPTH), 8'(OP_DEPTH)}, rd_data);
      for (int i = 0; i < OP_DEPTH + RES_DEPTH; i++)
      begin
         read_result(rd_data);
         check_value("r.data in order", exp_tab[N_FIXED + i], rd_data);
      end

      // Empty queue and bad read address.
      read_reg(axil_pkg::REG_RESULT, rd_data, resp);
      check_value("r.resp empty", axil_pkg::RESP_SLVERR, resp);
      check_value("r.data empty", 32'h0, rd_data);
      read_reg(4'hc, rd_data, resp);
      check_value("r.resp bad address", axil_pkg::RESP_SLVERR, resp);
      check_value("r.data bad address", 32'h0, rd_data);
      read_reg(axil_pkg::REG_STATUS, rd_data, resp);
      check_value("r.resp status", axil_pkg::RESP_OKAY, resp);
      check_value("r.data status", 32'h0, rd_data);

      $display("errors: %0d, checks: %0d", errors, checks);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule
